// ==== files.f ====
source/demosaic_pkg.sv
source/raster_ctrl.sv
source/neighbor_fetch.sv
source/bilinear_calc.sv
source/mem_port.sv
source/demosaic_top.sv
bench/demosaic_props.sv
bench/demosaic_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= demosaic_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/demosaic_tb.sv ====
`timescale 1ns/1ps

module demosaic_tb;

	localparam int COORD_W = 5;
	localparam int SIDE = 1 << COORD_W;
	localparam int NPIX = SIDE * SIDE;
	localparam int AW = 2 * COORD_W;
	localparam int DONE_LIMIT = 13 * NPIX + 64;
	localparam int QUIET_CYCLES = 64;
	localparam logic [31:0] SEED = 32'hc79f_3a7f;

	// kinds of mosaic
	localparam int RUN_RANDOM = 0;
	localparam int RUN_GREEN_LOW = 1;
	localparam int RUN_GREEN_HIGH = 2;

	logic clk;
	logic reset;
	logic in_en;
	logic [7:0] data_in;
	logic wr_g;
	logic wr_r;
	logic wr_b;
	logic [AW-1:0] addr_g;
	logic [AW-1:0] addr_r;
	logic [AW-1:0] addr_b;
	logic [7:0] wdata_g;
	logic [7:0] wdata_r;
	logic [7:0] wdata_b;
	logic [7:0] rdata_g;
	logic [7:0] rdata_r;
	logic [7:0] rdata_b;
	logic done;

	logic [7:0] mem_g [NPIX];
	logic [7:0] mem_r [NPIX];
	logic [7:0] mem_b [NPIX];
	logic [7:0] raw [NPIX];
	logic idle_check;
	logic fill_check;
	int cnt_g;
	int cnt_r;
	int cnt_b;

	demosaic_top #(.COORD_W(COORD_W)) dut_i (
		.clk(clk), .reset(reset), .in_en_i(in_en), .data_in_i(data_in),
		.wr_g_o(wr_g), .addr_g_o(addr_g), .wdata_g_o(wdata_g), .rdata_g_i(rdata_g),
		.wr_r_o(wr_r), .addr_r_o(addr_r), .wdata_r_o(wdata_r), .rdata_r_i(rdata_r),
		.wr_b_o(wr_b), .addr_b_o(addr_b), .wdata_b_o(wdata_b), .rdata_b_i(rdata_b),
		.done_o(done)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// memory models, combinational read
	// ------------------------------------------------------------------------
	always @(posedge clk) begin
		if (wr_g)
			mem_g[addr_g] <= wdata_g;
		if (wr_r)
			mem_r[addr_r] <= wdata_r;
		if (wr_b)
			mem_b[addr_b] <= wdata_b;
	end

	assign rdata_g = mem_g[addr_g];
	assign rdata_r = mem_r[addr_r];
	assign rdata_b = mem_b[addr_b];

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_fill_write(input logic wr, input logic [AW-1:0] addr,
			input logic [7:0] wdata, input string name, inout int count);
		if (wr && count < NPIX) begin
			assert (addr == AW'(count)) else
				fail_now($sformatf("FAILED addr_%s_o fill write %0d: got %h expected %h",
					name, count, addr, AW'(count)));
			assert (wdata == raw[count]) else
				fail_now($sformatf("FAILED wdata_%s_o fill write %0d: got %h expected %h",
					name, count, wdata, raw[count]));
			count++;
		end
	endtask

	// idle ports before the first strobe, fill writes in raster order
	always @(negedge clk) begin
		if (reset) begin
			cnt_g = 0;
			cnt_r = 0;
			cnt_b = 0;
		end
		if (idle_check) begin
			assert (!done && !wr_g && !wr_r && !wr_b) else
				fail_now("done or a memory write was active before the first input sample");
		end
		if (fill_check) begin
			check_fill_write(wr_g, addr_g, wdata_g, "g", cnt_g);
			check_fill_write(wr_r, addr_r, wdata_r, "r", cnt_r);
			check_fill_write(wr_b, addr_b, wdata_b, "b", cnt_b);
		end
	end

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------
	function automatic int fold_coord(input int v);
		if (v < 0)
			return v + 2;
		if (v >= SIDE)
			return v - 2;
		return v;
	endfunction

	function automatic int raw_at(input int r, input int c);
		return int'(raw[fold_coord(r) * SIDE + fold_coord(c)]);
	endfunction

	function automatic logic [7:0] to_pixel(input int acc);
		int q;
		if (acc < 0)
			return 8'd0;
		q = (acc + 4) / 8;
		if (q > 255)
			return 8'd255;
		return 8'(q);
	endfunction

	function automatic logic [7:0] expected_sample(input int r, input int c, input int ch);
		int v [13];
		int diag;
		int cross2;
		int hor;
		int ver;
		int other;
		int acc [3];
		v[demosaic_pkg::TAP_N] = raw_at(r - 1, c);
		v[demosaic_pkg::TAP_E] = raw_at(r, c + 1);
		v[demosaic_pkg::TAP_S] = raw_at(r + 1, c);
		v[demosaic_pkg::TAP_W] = raw_at(r, c - 1);
		v[demosaic_pkg::TAP_NW] = raw_at(r - 1, c - 1);
		v[demosaic_pkg::TAP_NE] = raw_at(r - 1, c + 1);
		v[demosaic_pkg::TAP_SE] = raw_at(r + 1, c + 1);
		v[demosaic_pkg::TAP_SW] = raw_at(r + 1, c - 1);
		v[demosaic_pkg::TAP_N2] = raw_at(r - 2, c);
		v[demosaic_pkg::TAP_E2] = raw_at(r, c + 2);
		v[demosaic_pkg::TAP_S2] = raw_at(r + 2, c);
		v[demosaic_pkg::TAP_W2] = raw_at(r, c - 2);
		v[demosaic_pkg::TAP_C] = raw_at(r, c);
		diag = v[4] + v[5] + v[6] + v[7];
		cross2 = v[8] + v[9] + v[10] + v[11];
		if ((r % 2) == (c % 2)) begin
			// green site
			hor = 4 * (v[1] + v[3]) + 5 * v[12] - diag + (v[8] + v[10]) / 2 - v[9] - v[11];
			ver = 4 * (v[0] + v[2]) + 5 * v[12] - diag + (v[9] + v[11]) / 2 - v[8] - v[10];
			acc[0] = 8 * v[12];
			acc[1] = (r % 2 == 0) ? hor : ver;
			acc[2] = (r % 2 == 0) ? ver : hor;
		end else begin
			other = 6 * v[12] + 2 * diag - (3 * cross2) / 2;
			acc[0] = 4 * v[12] + 2 * (v[0] + v[1] + v[2] + v[3]) - cross2;
			acc[1] = (r % 2 == 0) ? 8 * v[12] : other;
			acc[2] = (r % 2 == 0) ? other : 8 * v[12];
		end
		return to_pixel(acc[ch]);
	endfunction

	function automatic logic [7:0] stored_sample(input int idx, input int ch);
		case (ch)
			0: return mem_g[idx];
			1: return mem_r[idx];
			default: return mem_b[idx];
		endcase
	endfunction

	function automatic logic [7:0] make_sample(input int run_kind, input int k);
		logic green;
		green = ((k / SIDE) % 2) == ((k % SIDE) % 2);
		case (run_kind)
			RUN_GREEN_LOW: return green ? 8'h00 : 8'hff;
			RUN_GREEN_HIGH: return green ? 8'hff : 8'h00;
			default: return 8'($urandom);
		endcase
	endfunction

	task automatic compare_image(input int run_kind);
		logic [7:0] got;
		logic [7:0] exp;
		string cls;
		string name;
		for (int r = 0; r < SIDE; r++) begin
			for (int c = 0; c < SIDE; c++) begin
				for (int ch = 0; ch < 3; ch++) begin
					got = stored_sample(r * SIDE + c, ch);
					exp = expected_sample(r, c, ch);
					name = (ch == 0) ? "mem_g" : (ch == 1) ? "mem_r" : "mem_b";
					cls = (r < 2 || r >= SIDE - 2 || c < 2 || c >= SIDE - 2) ?
						"border" : "interior";
					assert (got == exp) else
						fail_now($sformatf("FAILED %s pixel %s[%0d][%0d]: got %h expected %h",
							cls, name, r, c, got, exp));
					if (run_kind != RUN_RANDOM) begin
						assert (got == 8'h00 || got == 8'hff) else
							fail_now($sformatf("FAILED clamp %s[%0d][%0d]: got %h",
								name, r, c, got));
					end
				end
			end
		end
	endtask

	// ------------------------------------------------------------------------
	// one complete run: reset, fill with gaps, walk, drain
	// ------------------------------------------------------------------------
	task automatic run_image(input int run_kind);
		int k;
		int waited;
		for (int i = 0; i < NPIX; i++)
			raw[i] = make_sample(run_kind, i);
		@(posedge clk);
		reset <= 1'b1;
		in_en <= 1'b0;
		idle_check = 1'b1;
		fill_check = 1'b0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		fill_check = 1'b1;
		k = 0;
		while (k < NPIX) begin
			@(posedge clk);
			if (($urandom % 4) != 0) begin
				in_en <= 1'b1;
				data_in <= raw[k];
				idle_check = 1'b0;
				k++;
			end else begin
				in_en <= 1'b0;
			end
		end
		@(posedge clk);
		in_en <= 1'b0;
		waited = 0;
		while (!done && waited < DONE_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		assert (done) else
			fail_now("done_o did not rise within the timeout after the last input sample");
		fill_check = 1'b0;
		assert (cnt_g == NPIX && cnt_r == NPIX && cnt_b == NPIX) else
			fail_now("fewer fill writes than input samples were seen on a memory port");
		for (int i = 0; i < QUIET_CYCLES; i++) begin
			@(negedge clk);
			assert (done) else
				fail_now("done_o fell after it had risen");
			assert (!(wr_g || wr_r || wr_b)) else
				fail_now("a memory write was issued after done_o rose");
		end
		compare_image(run_kind);
	endtask

	initial begin
		reset = 1'b1;
		in_en = 1'b0;
		data_in = 8'h00;
		idle_check = 1'b1;
		fill_check = 1'b0;
		void'($urandom(SEED));
		run_image(RUN_RANDOM);
		run_image(RUN_GREEN_LOW);
		run_image(RUN_GREEN_HIGH);
		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== bench/demosaic_props.sv ====
`timescale 1ns/1ps

module demosaic_props (
	input logic clk,
	input logic reset,
	input logic res_we_i,
	input logic pending_i,
	input logic wr_i,
	input logic rd_en_i
);

	// ------------------------------------------------------------------------
	// write port rules
	// ------------------------------------------------------------------------
	// held write always gone before the next result
	assert property (@(posedge clk) disable iff (reset) res_we_i |-> !pending_i)
		else $error("result strobe arrived while a write was still held");

	// a write held back by reads leaves within one window
	assert property (@(posedge clk) disable iff (reset)
			pending_i && rd_en_i |-> ##[1:13] wr_i)
		else $error("held write was not issued within one window of reads");

	assert property (@(posedge clk) reset |=> !wr_i)
		else $error("write strobe high right after reset");

endmodule

bind mem_port demosaic_props u_props (
	.clk(clk),
	.reset(reset),
	.res_we_i(res_we_i),
	.pending_i(pending_o),
	.wr_i(wr_o),
	.rd_en_i(rd_en_i)
);

// ==== source/demosaic_top.sv ====
`timescale 1ns/1ps

module demosaic_top #(
	parameter int COORD_W = 7
) (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           in_en_i,
	input  logic [demosaic_pkg::PIX_W-1:0] data_in_i,
	output logic                           wr_g_o,
	output logic [2*COORD_W-1:0]           addr_g_o,
	output logic [demosaic_pkg::PIX_W-1:0] wdata_g_o,
	input  logic [demosaic_pkg::PIX_W-1:0] rdata_g_i,
	output logic                           wr_r_o,
	output logic [2*COORD_W-1:0]           addr_r_o,
	output logic [demosaic_pkg::PIX_W-1:0] wdata_r_o,
	input  logic [demosaic_pkg::PIX_W-1:0] rdata_r_i,
	output logic                           wr_b_o,
	output logic [2*COORD_W-1:0]           addr_b_o,
	output logic [demosaic_pkg::PIX_W-1:0] wdata_b_o,
	input  logic [demosaic_pkg::PIX_W-1:0] rdata_b_i,
	output logic                           done_o
);

	demosaic_pkg::phase_e phase;
	logic [COORD_W-1:0] row;
	logic [COORD_W-1:0] col;
	logic [3:0] step;
	logic fill_we;
	logic [2:0] pending;
	logic [2:0] rd_en;
	logic [2*COORD_W-1:0] rd_addr;
	logic [demosaic_pkg::WINDOW_TAPS-1:0][2:0][demosaic_pkg::PIX_W-1:0] window;
	logic [COORD_W-1:0] win_row;
	logic [COORD_W-1:0] win_col;
	logic res_we;
	logic [COORD_W-1:0] res_row;
	logic [COORD_W-1:0] res_col;
	logic [2:0][demosaic_pkg::PIX_W-1:0] res_data;
	logic [2:0] wr;
	logic [2:0][2*COORD_W-1:0] addr;
	logic [2:0][demosaic_pkg::PIX_W-1:0] wdata;

	raster_ctrl #(.COORD_W(COORD_W)) u_raster (
		.clk(clk),
		.reset(reset),
		.in_en_i(in_en_i),
		.pending_i(pending),
		.phase_o(phase),
		.row_o(row),
		.col_o(col),
		.step_o(step),
		.fill_we_o(fill_we),
		.done_o(done_o)
	);

	neighbor_fetch #(.COORD_W(COORD_W)) u_fetch (
		.clk(clk),
		.phase_i(phase),
		.row_i(row),
		.col_i(col),
		.step_i(step),
		.rdata_g_i(rdata_g_i),
		.rdata_r_i(rdata_r_i),
		.rdata_b_i(rdata_b_i),
		.rd_en_o(rd_en),
		.rd_addr_o(rd_addr),
		.window_o(window),
		.win_row_o(win_row),
		.win_col_o(win_col)
	);

	bilinear_calc #(.COORD_W(COORD_W)) u_calc (
		.clk(clk),
		.reset(reset),
		.phase_i(phase),
		.step_i(step),
		.window_i(window),
		.win_row_i(win_row),
		.win_col_i(win_col),
		.res_we_o(res_we),
		.res_row_o(res_row),
		.res_col_o(res_col),
		.res_data_o(res_data)
	);

	// one write port per colour memory
	for (genvar gi = 0; gi < 3; gi++) begin : g_port
		mem_port #(.COORD_W(COORD_W)) u_port (
			.clk(clk),
			.reset(reset),
			.fill_we_i(fill_we),
			.fill_row_i(row),
			.fill_col_i(col),
			.fill_data_i(data_in_i),
			.res_we_i(res_we),
			.res_row_i(res_row),
			.res_col_i(res_col),
			.res_data_i(res_data[gi]),
			.rd_en_i(rd_en[gi]),
			.rd_addr_i(rd_addr),
			.wr_o(wr[gi]),
			.addr_o(addr[gi]),
			.wdata_o(wdata[gi]),
			.pending_o(pending[gi])
		);
	end

	assign wr_g_o = wr[demosaic_pkg::CH_GREEN];
	assign addr_g_o = addr[demosaic_pkg::CH_GREEN];
	assign wdata_g_o = wdata[demosaic_pkg::CH_GREEN];
	assign wr_r_o = wr[demosaic_pkg::CH_RED];
	assign addr_r_o = addr[demosaic_pkg::CH_RED];
	assign wdata_r_o = wdata[demosaic_pkg::CH_RED];
	assign wr_b_o = wr[demosaic_pkg::CH_BLUE];
	assign addr_b_o = addr[demosaic_pkg::CH_BLUE];
	assign wdata_b_o = wdata[demosaic_pkg::CH_BLUE];

endmodule

// ==== source/mem_port.sv ====
`timescale 1ns/1ps

module mem_port #(
	parameter int COORD_W = 7
) (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           fill_we_i,
	input  logic [COORD_W-1:0]             fill_row_i,
	input  logic [COORD_W-1:0]             fill_col_i,
	input  logic [demosaic_pkg::PIX_W-1:0] fill_data_i,
	input  logic                           res_we_i,
	input  logic [COORD_W-1:0]             res_row_i,
	input  logic [COORD_W-1:0]             res_col_i,
	input  logic [demosaic_pkg::PIX_W-1:0] res_data_i,
	input  logic                           rd_en_i,
	input  logic [2*COORD_W-1:0]           rd_addr_i,
	output logic                           wr_o,
	output logic [2*COORD_W-1:0]           addr_o,
	output logic [demosaic_pkg::PIX_W-1:0] wdata_o,
	output logic                           pending_o
);

	logic pending_q;
	logic [2*COORD_W-1:0] hold_addr;
	logic [demosaic_pkg::PIX_W-1:0] hold_data;

	// a new write may land in the cycle the old one goes out
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pending_q <= 1'b0;
		end else if (fill_we_i || res_we_i) begin
			pending_q <= 1'b1;
		end else if (wr_o) begin
			pending_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_we_i) begin
			hold_addr <= {fill_row_i, fill_col_i};
			hold_data <= fill_data_i;
		end else if (res_we_i) begin
			hold_addr <= {res_row_i, res_col_i};
			hold_data <= res_data_i;
		end
	end

	// reads win, the write waits for a free step
	assign wr_o = pending_q && !rd_en_i;
	assign addr_o = wr_o ? hold_addr : rd_addr_i;
	assign wdata_o = hold_data;
	assign pending_o = pending_q;

endmodule

// ==== source/bilinear_calc.sv ====
`timescale 1ns/1ps

module bilinear_calc #(
	parameter int COORD_W = 7
) (
	input  logic                                  clk,
	input  logic                                  reset,
	input  demosaic_pkg::phase_e                  phase_i,
	input  logic [3:0]                            step_i,
	input  logic [demosaic_pkg::WINDOW_TAPS-1:0][2:0][demosaic_pkg::PIX_W-1:0] window_i,
	input  logic [COORD_W-1:0]                    win_row_i,
	input  logic [COORD_W-1:0]                    win_col_i,
	output logic                                  res_we_o,
	output logic [COORD_W-1:0]                    res_row_o,
	output logic [COORD_W-1:0]                    res_col_o,
	output logic [2:0][demosaic_pkg::PIX_W-1:0]   res_data_o
);

	localparam logic [3:0] LAST_STEP = 4'(demosaic_pkg::WINDOW_TAPS - 1);

	typedef logic signed [demosaic_pkg::ACC_W-1:0] acc_t;

	acc_t ctr [3];
	acc_t hor1 [3];
	acc_t ver1 [3];
	acc_t hor2 [3];
	acc_t ver2 [3];
	acc_t diag [3];
	acc_t est [3];
	logic calc_pend;

	function automatic acc_t px(input logic [demosaic_pkg::PIX_W-1:0] v);
		return $signed({{(demosaic_pkg::ACC_W - demosaic_pkg::PIX_W){1'b0}}, v});
	endfunction

	// missing red or blue at a green site
	function automatic acc_t green_site(input acc_t ctr_g, input acc_t diag_g, input acc_t near,
			input acc_t along2, input acc_t across2);
		return (near <<< 2) + (ctr_g <<< 2) + ctr_g - diag_g + (along2 >>> 1) - across2;
	endfunction

	function automatic acc_t green_at_colour(input acc_t ctr_c, input acc_t cross1_g,
			input acc_t cross2_c);
		return (ctr_c <<< 2) + (cross1_g <<< 1) - cross2_c;
	endfunction

	// blue at red or red at blue, 3/2 of the outer cross
	function automatic acc_t other_at_colour(input acc_t ctr_c, input acc_t diag_o,
			input acc_t cross2_c);
		return (ctr_c <<< 2) + (ctr_c <<< 1) + (diag_o <<< 1)
			- (((cross2_c <<< 1) + cross2_c) >>> 1);
	endfunction

	function automatic logic [demosaic_pkg::PIX_W-1:0] round_clamp(input acc_t acc);
		logic [demosaic_pkg::ACC_W-1:0] q;
		q = $unsigned(acc >>> 3) + {{(demosaic_pkg::ACC_W - 1){1'b0}}, acc[2]};
		if (acc[demosaic_pkg::ACC_W-1]) begin
			return '0;
		end
		if (q[demosaic_pkg::ACC_W-1:demosaic_pkg::PIX_W] != '0) begin
			return '1;
		end
		return q[demosaic_pkg::PIX_W-1:0];
	endfunction

	// -------------------------------------------------------------------------
	// partial sums per channel
	// -------------------------------------------------------------------------
	always_comb begin
		for (int ch = 0; ch < 3; ch++) begin
			ctr[ch] = px(window_i[demosaic_pkg::TAP_C][ch]);
			hor1[ch] = px(window_i[demosaic_pkg::TAP_E][ch]) + px(window_i[demosaic_pkg::TAP_W][ch]);
			ver1[ch] = px(window_i[demosaic_pkg::TAP_N][ch]) + px(window_i[demosaic_pkg::TAP_S][ch]);
			hor2[ch] = px(window_i[demosaic_pkg::TAP_E2][ch])
				+ px(window_i[demosaic_pkg::TAP_W2][ch]);
			ver2[ch] = px(window_i[demosaic_pkg::TAP_N2][ch])
				+ px(window_i[demosaic_pkg::TAP_S2][ch]);
			diag[ch] = px(window_i[demosaic_pkg::TAP_NW][ch]) + px(window_i[demosaic_pkg::TAP_NE][ch])
				+ px(window_i[demosaic_pkg::TAP_SE][ch]) + px(window_i[demosaic_pkg::TAP_SW][ch]);
		end
	end

	always_comb begin : kernel
		acc_t g_c;
		acc_t r_c;
		acc_t b_c;
		acc_t cross1_g;
		acc_t cross2_r;
		acc_t cross2_b;
		g_c = ctr[demosaic_pkg::CH_GREEN];
		r_c = ctr[demosaic_pkg::CH_RED];
		b_c = ctr[demosaic_pkg::CH_BLUE];
		cross1_g = hor1[demosaic_pkg::CH_GREEN] + ver1[demosaic_pkg::CH_GREEN];
		cross2_r = hor2[demosaic_pkg::CH_RED] + ver2[demosaic_pkg::CH_RED];
		cross2_b = hor2[demosaic_pkg::CH_BLUE] + ver2[demosaic_pkg::CH_BLUE];
		case ({win_row_i[0], win_col_i[0]})
			2'b00: begin
				est[demosaic_pkg::CH_GREEN] = g_c <<< 3;
				est[demosaic_pkg::CH_RED] = green_site(g_c, diag[demosaic_pkg::CH_GREEN],
					hor1[demosaic_pkg::CH_RED], ver2[demosaic_pkg::CH_GREEN],
					hor2[demosaic_pkg::CH_GREEN]);
				est[demosaic_pkg::CH_BLUE] = green_site(g_c, diag[demosaic_pkg::CH_GREEN],
					ver1[demosaic_pkg::CH_BLUE], hor2[demosaic_pkg::CH_GREEN],
					ver2[demosaic_pkg::CH_GREEN]);
			end
			2'b11: begin
				est[demosaic_pkg::CH_GREEN] = g_c <<< 3;
				est[demosaic_pkg::CH_RED] = green_site(g_c, diag[demosaic_pkg::CH_GREEN],
					ver1[demosaic_pkg::CH_RED], hor2[demosaic_pkg::CH_GREEN],
					ver2[demosaic_pkg::CH_GREEN]);
				est[demosaic_pkg::CH_BLUE] = green_site(g_c, diag[demosaic_pkg::CH_GREEN],
					hor1[demosaic_pkg::CH_BLUE], ver2[demosaic_pkg::CH_GREEN],
					hor2[demosaic_pkg::CH_GREEN]);
			end
			2'b01: begin
				est[demosaic_pkg::CH_GREEN] = green_at_colour(r_c, cross1_g, cross2_r);
				est[demosaic_pkg::CH_RED] = r_c <<< 3;
				est[demosaic_pkg::CH_BLUE] = other_at_colour(r_c, diag[demosaic_pkg::CH_BLUE],
					cross2_r);
			end
			default: begin
				est[demosaic_pkg::CH_GREEN] = green_at_colour(b_c, cross1_g, cross2_b);
				est[demosaic_pkg::CH_RED] = other_at_colour(b_c, diag[demosaic_pkg::CH_RED],
					cross2_b);
				est[demosaic_pkg::CH_BLUE] = b_c <<< 3;
			end
		endcase
	end

	// window complete one cycle after its last step
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			calc_pend <= 1'b0;
			res_we_o <= 1'b0;
		end else begin
			calc_pend <= (phase_i == demosaic_pkg::PH_BILINEAR) && (step_i == LAST_STEP);
			res_we_o <= calc_pend;
		end
	end

	always_ff @(posedge clk) begin
		if (calc_pend) begin
			res_row_o <= win_row_i;
			res_col_o <= win_col_i;
			for (int ch = 0; ch < 3; ch++) begin
				res_data_o[ch] <= round_clamp(est[ch]);
			end
		end
	end

endmodule

// ==== source/neighbor_fetch.sv ====
`timescale 1ns/1ps

module neighbor_fetch #(
	parameter int COORD_W = 7
) (
	input  logic                                  clk,
	input  demosaic_pkg::phase_e                  phase_i,
	input  logic [COORD_W-1:0]                    row_i,
	input  logic [COORD_W-1:0]                    col_i,
	input  logic [3:0]                            step_i,
	input  logic [demosaic_pkg::PIX_W-1:0]        rdata_g_i,
	input  logic [demosaic_pkg::PIX_W-1:0]        rdata_r_i,
	input  logic [demosaic_pkg::PIX_W-1:0]        rdata_b_i,
	output logic [2:0]                            rd_en_o,
	output logic [2*COORD_W-1:0]                  rd_addr_o,
	output logic [demosaic_pkg::WINDOW_TAPS-1:0][2:0][demosaic_pkg::PIX_W-1:0] window_o,
	output logic [COORD_W-1:0]                    win_row_o,
	output logic [COORD_W-1:0]                    win_col_o
);

	localparam logic [3:0] LAST_STEP = 4'(demosaic_pkg::WINDOW_TAPS - 1);
	localparam logic signed [COORD_W+1:0] SIDE = 1 << COORD_W;
	localparam logic signed [COORD_W+1:0] STEP2 = 2;

	// tap offsets
	localparam logic signed [2:0] M2 = -3'sd2;
	localparam logic signed [2:0] M1 = -3'sd1;
	localparam logic signed [2:0] Z0 = 3'sd0;
	localparam logic signed [2:0] P1 = 3'sd1;
	localparam logic signed [2:0] P2 = 3'sd2;

	logic signed [2:0] d_row;
	logic signed [2:0] d_col;
	logic signed [COORD_W+1:0] raw_row;
	logic signed [COORD_W+1:0] raw_col;
	logic [COORD_W-1:0] tap_row;
	logic [COORD_W-1:0] tap_col;
	demosaic_pkg::chan_e tap_chan;
	logic [2:0][demosaic_pkg::PIX_W-1:0] rdata;

	// reflect across the border, parity of the coordinate is kept
	function automatic logic [COORD_W-1:0] mirror(input logic signed [COORD_W+1:0] v);
		logic signed [COORD_W+1:0] m;
		m = v;
		if (v[COORD_W+1]) begin
			m = v + STEP2;
		end else if (v >= SIDE) begin
			m = v - STEP2;
		end
		return m[COORD_W-1:0];
	endfunction

	always_comb begin
		case (step_i)
			demosaic_pkg::TAP_N:  {d_row, d_col} = {M1, Z0};
			demosaic_pkg::TAP_E:  {d_row, d_col} = {Z0, P1};
			demosaic_pkg::TAP_S:  {d_row, d_col} = {P1, Z0};
			demosaic_pkg::TAP_W:  {d_row, d_col} = {Z0, M1};
			demosaic_pkg::TAP_NW: {d_row, d_col} = {M1, M1};
			demosaic_pkg::TAP_NE: {d_row, d_col} = {M1, P1};
			demosaic_pkg::TAP_SE: {d_row, d_col} = {P1, P1};
			demosaic_pkg::TAP_SW: {d_row, d_col} = {P1, M1};
			demosaic_pkg::TAP_N2: {d_row, d_col} = {M2, Z0};
			demosaic_pkg::TAP_E2: {d_row, d_col} = {Z0, P2};
			demosaic_pkg::TAP_S2: {d_row, d_col} = {P2, Z0};
			demosaic_pkg::TAP_W2: {d_row, d_col} = {Z0, M2};
			default:              {d_row, d_col} = {Z0, Z0};
		endcase
	end

	assign raw_row = $signed({2'b00, row_i}) + d_row;
	assign raw_col = $signed({2'b00, col_i}) + d_col;
	assign tap_row = mirror(raw_row);
	assign tap_col = mirror(raw_col);
	assign rd_addr_o = {tap_row, tap_col};

	// native colour of the Bayer site
	always_comb begin
		case ({tap_row[0], tap_col[0]})
			2'b01:   tap_chan = demosaic_pkg::CH_RED;
			2'b10:   tap_chan = demosaic_pkg::CH_BLUE;
			default: tap_chan = demosaic_pkg::CH_GREEN;
		endcase
	end

	assign rd_en_o = (phase_i == demosaic_pkg::PH_BILINEAR) ? (3'b001 << tap_chan) : 3'b000;

	assign rdata[demosaic_pkg::CH_GREEN] = rdata_g_i;
	assign rdata[demosaic_pkg::CH_RED] = rdata_r_i;
	assign rdata[demosaic_pkg::CH_BLUE] = rdata_b_i;

	// window cache, one slot per step and channel
	always_ff @(posedge clk) begin
		if (phase_i == demosaic_pkg::PH_BILINEAR) begin
			for (int ch = 0; ch < 3; ch++) begin
				if (rd_en_o[ch]) begin
					window_o[step_i][ch] <= rdata[ch];
				end
			end
			if (step_i == LAST_STEP) begin
				win_row_o <= row_i;
				win_col_o <= col_i;
			end
		end
	end

endmodule

// ==== source/raster_ctrl.sv ====
`timescale 1ns/1ps

module raster_ctrl #(
	parameter int COORD_W = 7
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 in_en_i,
	input  logic [2:0]           pending_i,
	output demosaic_pkg::phase_e phase_o,
	output logic [COORD_W-1:0]   row_o,
	output logic [COORD_W-1:0]   col_o,
	output logic [3:0]           step_o,
	output logic                 fill_we_o,
	output logic                 done_o
);

	localparam logic [3:0] LAST_STEP = 4'(demosaic_pkg::WINDOW_TAPS - 1);
	// last result reaches the ports two cycles into the drain
	localparam logic [3:0] DRAIN_WAIT = 4'd2;

	demosaic_pkg::phase_e phase_q;
	logic [COORD_W-1:0] row_q;
	logic [COORD_W-1:0] col_q;
	logic [3:0] step_q;
	logic done_q;
	logic last_pixel;

	assign last_pixel = &{row_q, col_q};

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			phase_q <= demosaic_pkg::PH_FILL;
			row_q <= '0;
			col_q <= '0;
			step_q <= '0;
			done_q <= 1'b0;
		end else begin
			case (phase_q)
				demosaic_pkg::PH_FILL: begin
					// one raw pixel per strobe
					if (in_en_i) begin
						{row_q, col_q} <= {row_q, col_q} + 1'b1;
						if (last_pixel) begin
							phase_q <= demosaic_pkg::PH_BILINEAR;
						end
					end
				end
				demosaic_pkg::PH_BILINEAR: begin
					if (step_q == LAST_STEP) begin
						step_q <= '0;
						{row_q, col_q} <= {row_q, col_q} + 1'b1;
						if (last_pixel) begin
							phase_q <= demosaic_pkg::PH_DRAIN;
						end
					end else begin
						step_q <= step_q + 1'b1;
					end
				end
				demosaic_pkg::PH_DRAIN: begin
					if (step_q < DRAIN_WAIT) begin
						step_q <= step_q + 1'b1;
					end else if (pending_i == 3'b000) begin
						phase_q <= demosaic_pkg::PH_DONE;
						done_q <= 1'b1;
					end
				end
				default: begin
					done_q <= 1'b1;
				end
			endcase
		end
	end

	assign fill_we_o = (phase_q == demosaic_pkg::PH_FILL) && in_en_i;

	assign phase_o = phase_q;
	assign row_o = row_q;
	assign col_o = col_q;
	assign step_o = step_q;
	assign done_o = done_q;

endmodule

// ==== source/demosaic_pkg.sv ====
package demosaic_pkg;

	localparam int PIX_W = 8;
	// signed kernel sums, scaled by 8
	localparam int ACC_W = 14;
	localparam int WINDOW_TAPS = 13;

	typedef enum logic [1:0] {
		PH_FILL,
		PH_BILINEAR,
		PH_DRAIN,
		PH_DONE
	} phase_e;

	typedef enum logic [1:0] {
		CH_GREEN,
		CH_RED,
		CH_BLUE
	} chan_e;

	// -------------------------------------------------------------------------
	// window taps, one per fetch step, offsets given as (row, col)
	// -------------------------------------------------------------------------
	// cross at distance 1
	localparam logic [3:0] TAP_N = 4'd0;
	localparam logic [3:0] TAP_E = 4'd1;
	localparam logic [3:0] TAP_S = 4'd2;
	localparam logic [3:0] TAP_W = 4'd3;

	// diagonals
	localparam logic [3:0] TAP_NW = 4'd4;
	localparam logic [3:0] TAP_NE = 4'd5;
	localparam logic [3:0] TAP_SE = 4'd6;
	localparam logic [3:0] TAP_SW = 4'd7;

	// cross at distance 2
	localparam logic [3:0] TAP_N2 = 4'd8;
	localparam logic [3:0] TAP_E2 = 4'd9;
	localparam logic [3:0] TAP_S2 = 4'd10;
	localparam logic [3:0] TAP_W2 = 4'd11;

	localparam logic [3:0] TAP_C = 4'd12;

endpackage
